// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - time_counter.sv
  - pipe_ctrl.sv
  - decode_stage.sv
  - operand_forward.sv
  - reg_file.sv
  - mul_unit.sv
  - exec_stage.sv
  - mini_core_top.sv
  - target: test
    files:
      - tb_mini_core.sv

// ==== core_pkg.sv ====
package core_pkg;

    // Datapath
    localparam int XLEN = 32;

    // Register file
    localparam int REG_NUM = 32;
    localparam int REG_AW  = 5;

    // Time counter
    localparam int CNT_W = 64;

    // Iterative multiplier, one chunk of the multiplier per step
    localparam int MUL_STEPS = 4;
    localparam int MUL_CHUNK = 8;

    // Step counter must hold the value MUL_STEPS
    localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

endpackage

// ==== decode_stage.sv ====
module decode_stage
    import isa_pkg::*, core_pkg::*;
(
    input  logic              aclk,
    input  logic              reset,
    input  logic              id_load,
    input  logic [XLEN-1:0]   inst_pc,
    input  logic [INST_W-1:0] inst_word,
    output logic [XLEN-1:0]   id_pc,
    output opcode_e           id_op,
    output logic [REG_AW-1:0] id_rd,
    output logic [XLEN-1:0]   id_imm,
    output logic [REG_AW-1:0] rf_raddr1,
    output logic [REG_AW-1:0] rf_raddr2
);

    logic [INST_W-1:0]        id_inst;
    logic [OPC_MSB-OPC_LSB:0] opc_field;

    // Instruction register clears to an all-zero word, which is a NOP
    always_ff @(posedge aclk)
    begin
        if (reset)
            id_inst <= '0;
        else if (id_load)
            id_inst <= inst_word;
    end

    always_ff @(posedge aclk)
    begin
        if (id_load)
            id_pc <= inst_pc;
    end

    assign opc_field = id_inst[OPC_MSB:OPC_LSB];

    // Unused opcode values fall back to NOP
    always_comb
    begin
        case (opc_field)
            OP_NOP,
            OP_ADD,
            OP_SUB,
            OP_ADDI,
            OP_MUL,
            OP_RDCNTVL,
            OP_RDCNTVH: id_op = opcode_e'(opc_field);
            default:    id_op = OP_NOP;
        endcase
    end

    assign id_rd = id_inst[RD_LSB +: REG_AW];

    // Sign extension of the low immediate
    assign id_imm = {{(XLEN - IMM_W){id_inst[IMM_W-1]}}, id_inst[IMM_W-1:0]};

    // Source fields go straight to the register file
    assign rf_raddr1 = id_inst[RJ_LSB +: REG_AW];
    assign rf_raddr2 = id_inst[RK_LSB +: REG_AW];

endmodule

// ==== exec_stage.sv ====
module exec_stage
    import isa_pkg::*, core_pkg::*;
(
    input  logic              aclk,
    input  logic              reset,
    input  logic              ex_load,
    input  logic              wb_load,
    input  logic              ex_valid,
    input  logic [XLEN-1:0]   id_pc,
    input  opcode_e           id_op,
    input  logic [REG_AW-1:0] id_rd,
    input  logic [XLEN-1:0]   id_imm,
    input  logic [XLEN-1:0]   src1,
    input  logic [XLEN-1:0]   src2,
    input  logic [CNT_W-1:0]  count,
    output logic              ex_ready_go,
    output logic              ex_wen,
    output logic [REG_AW-1:0] ex_rd,
    output logic [XLEN-1:0]   ex_result,
    output logic [XLEN-1:0]   wb_pc,
    output logic              wb_we,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]   wb_result
);

    logic [XLEN-1:0] ex_pc;
    opcode_e         ex_op;
    logic [XLEN-1:0] ex_imm;
    logic [XLEN-1:0] ex_src1;
    logic [XLEN-1:0] ex_src2;
    logic            mul_done;
    logic [XLEN-1:0] mul_product;

    always_ff @(posedge aclk)
    begin
        if (ex_load)
        begin
            ex_pc   <= id_pc;
            ex_op   <= id_op;
            ex_rd   <= id_rd;
            ex_imm  <= id_imm;
            ex_src1 <= src1;
            ex_src2 <= src2;
        end
    end

    // Multiply kicks off on the same edge the operands are captured
    mul_unit u_mul (
        .aclk         (aclk),
        .reset        (reset),
        .start        (ex_load && id_op == OP_MUL),
        .multiplicand (src1),
        .multiplier   (src2),
        .done         (mul_done),
        .product      (mul_product)
    );

    assign ex_ready_go = !(ex_valid && ex_op == OP_MUL && !mul_done);

    always_comb
    begin
        ex_wen    = 1'b1;
        ex_result = '0;
        case (ex_op)
            OP_ADD:     ex_result = ex_src1 + ex_src2;
            OP_SUB:     ex_result = ex_src1 - ex_src2;
            OP_ADDI:    ex_result = ex_src1 + ex_imm;
            OP_MUL:     ex_result = mul_product;
            // Counter is sampled in the single cycle a read spends here
            OP_RDCNTVL: ex_result = count[XLEN-1:0];
            OP_RDCNTVH: ex_result = count[CNT_W-1:XLEN];
            default:    ex_wen    = 1'b0;
        endcase
    end

    // Writeback data
    always_ff @(posedge aclk)
    begin
        if (wb_load)
        begin
            wb_pc     <= ex_pc;
            wb_rd     <= ex_rd;
            wb_result <= ex_result;
        end
    end

    // Write strobe drops with every bubble into writeback
    always_ff @(posedge aclk)
    begin
        if (reset)
            wb_we <= 1'b0;
        else
            wb_we <= wb_load && ex_wen && ex_rd != '0;
    end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    // Instruction word
    localparam int INST_W = 32;

    // Field positions
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int RD_LSB  = 23;
    localparam int RJ_LSB  = 18;
    localparam int RK_LSB  = 13;

    // Immediate sits at the bottom of the word, sign-extended on decode
    localparam int IMM_W = 12;

    // Opcodes, any other code decodes as OP_NOP
    typedef enum logic [3:0] {
        OP_NOP     = 4'h0,
        OP_ADD     = 4'h1,
        OP_SUB     = 4'h2,
        OP_ADDI    = 4'h3,
        OP_MUL     = 4'h4,
        OP_RDCNTVL = 4'h5,
        OP_RDCNTVH = 4'h6
    } opcode_e;

endpackage

// ==== mini_core_top.f ====
isa_pkg.sv
core_pkg.sv
time_counter.sv
pipe_ctrl.sv
decode_stage.sv
operand_forward.sv
reg_file.sv
mul_unit.sv
exec_stage.sv
mini_core_top.sv
tb_mini_core.sv

// ==== mini_core_top.sv ====
module mini_core_top
    import isa_pkg::*, core_pkg::*;
(
    input  logic              aclk,
    input  logic              reset,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst_pc,
    input  logic [INST_W-1:0] inst_word,
    output logic              inst_allow,
    output logic [XLEN-1:0]   debug_wb_pc,
    output logic              debug_wb_rf_we,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]   debug_wb_rf_wdata
);

    logic              id_load, ex_load, wb_load;
    logic              id_valid, ex_valid, wb_valid;
    logic              ex_ready_go;
    logic [CNT_W-1:0]  count;
    logic [XLEN-1:0]   id_pc;
    opcode_e           id_op;
    logic [REG_AW-1:0] id_rd;
    logic [XLEN-1:0]   id_imm;
    logic [REG_AW-1:0] rf_raddr1, rf_raddr2;
    logic [XLEN-1:0]   rf_rdata1, rf_rdata2;
    logic [XLEN-1:0]   src1, src2;
    logic              ex_wen;
    logic [REG_AW-1:0] ex_rd;
    logic [XLEN-1:0]   ex_result;
    logic              wb_we;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_result;

    time_counter u_timer (.aclk(aclk), .reset(reset), .count(count));

    pipe_ctrl u_ctrl (
        .aclk(aclk), .reset(reset), .inst_valid(inst_valid), .ex_ready_go(ex_ready_go),
        .inst_allow(inst_allow), .id_load(id_load), .ex_load(ex_load), .wb_load(wb_load),
        .id_valid(id_valid), .ex_valid(ex_valid), .wb_valid(wb_valid)
    );

    decode_stage u_id (
        .aclk(aclk), .reset(reset), .id_load(id_load), .inst_pc(inst_pc),
        .inst_word(inst_word), .id_pc(id_pc), .id_op(id_op), .id_rd(id_rd),
        .id_imm(id_imm), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2)
    );

    reg_file u_rf (
        .aclk(aclk), .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
        .rdata2(rf_rdata2), .we(wb_we), .waddr(wb_rd), .wdata(wb_result)
    );

    operand_forward u_fwd (
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2), .rf_rdata1(rf_rdata1),
        .rf_rdata2(rf_rdata2), .ex_valid(ex_valid), .ex_wen(ex_wen), .ex_rd(ex_rd),
        .ex_result(ex_result), .wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd),
        .wb_result(wb_result), .src1(src1), .src2(src2)
    );

    exec_stage u_ex (
        .aclk(aclk), .reset(reset), .ex_load(ex_load), .wb_load(wb_load),
        .ex_valid(ex_valid), .id_pc(id_pc), .id_op(id_op), .id_rd(id_rd),
        .id_imm(id_imm), .src1(src1), .src2(src2), .count(count),
        .ex_ready_go(ex_ready_go), .ex_wen(ex_wen), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_pc(debug_wb_pc), .wb_we(wb_we), .wb_rd(wb_rd), .wb_result(wb_result)
    );

    // Trace mirrors the register file write port
    assign debug_wb_rf_we    = wb_we;
    assign debug_wb_rf_wnum  = wb_rd;
    assign debug_wb_rf_wdata = wb_result;

endmodule

// ==== mul_unit.sv ====
module mul_unit
    import core_pkg::*;
(
    input  logic            aclk,
    input  logic            reset,
    input  logic            start,
    input  logic [XLEN-1:0] multiplicand,
    input  logic [XLEN-1:0] multiplier,
    output logic            done,
    output logic [XLEN-1:0] product
);

    logic [MUL_CNT_W-1:0] step;
    logic [XLEN-1:0]      mcand;
    logic [XLEN-1:0]      mplier;
    logic [XLEN-1:0]      acc;

    // Parked at MUL_STEPS while idle, so done holds until the next start
    always_ff @(posedge aclk)
    begin
        if (reset)
            step <= MUL_CNT_W'(MUL_STEPS);
        else if (start)
            step <= MUL_CNT_W'(1);
        else if (!done)
            step <= step + 1'b1;
    end

    // First chunk is added on the start edge itself
    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            acc    <= multiplicand * XLEN'(multiplier[MUL_CHUNK-1:0]);
            mcand  <= multiplicand << MUL_CHUNK;
            mplier <= multiplier >> MUL_CHUNK;
        end
        else if (!done)
        begin
            acc    <= acc + mcand * XLEN'(mplier[MUL_CHUNK-1:0]);
            mcand  <= mcand << MUL_CHUNK;
            mplier <= mplier >> MUL_CHUNK;
        end
    end

    assign done    = (step == MUL_CNT_W'(MUL_STEPS));
    assign product = acc;

endmodule

// ==== operand_forward.sv ====
module operand_forward
    import core_pkg::*;
(
    input  logic [REG_AW-1:0] rf_raddr1,
    input  logic [REG_AW-1:0] rf_raddr2,
    input  logic [XLEN-1:0]   rf_rdata1,
    input  logic [XLEN-1:0]   rf_rdata2,
    input  logic              ex_valid,
    input  logic              ex_wen,
    input  logic [REG_AW-1:0] ex_rd,
    input  logic [XLEN-1:0]   ex_result,
    input  logic              wb_valid,
    input  logic              wb_we,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_result,
    output logic [XLEN-1:0]   src1,
    output logic [XLEN-1:0]   src2
);

    // Youngest producer wins, register zero is never forwarded
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   rf_value,
        input logic              ex_fwd,
        input logic [REG_AW-1:0] ex_dst,
        input logic [XLEN-1:0]   ex_value,
        input logic              wb_fwd,
        input logic [REG_AW-1:0] wb_dst,
        input logic [XLEN-1:0]   wb_value
    );
        logic [XLEN-1:0] value;
        value = rf_value;
        if (addr != '0)
        begin
            if (ex_fwd && ex_dst == addr)
                value = ex_value;
            else if (wb_fwd && wb_dst == addr)
                value = wb_value;
        end
        return value;
    endfunction

    assign src1 = pick(rf_raddr1, rf_rdata1, ex_valid && ex_wen, ex_rd, ex_result,
                       wb_valid && wb_we, wb_rd, wb_result);
    assign src2 = pick(rf_raddr2, rf_rdata2, ex_valid && ex_wen, ex_rd, ex_result,
                       wb_valid && wb_we, wb_rd, wb_result);

endmodule

// ==== pipe_ctrl.sv ====
module pipe_ctrl (
    input  logic aclk,
    input  logic reset,
    input  logic inst_valid,
    input  logic ex_ready_go,
    output logic inst_allow,
    output logic id_load,
    output logic ex_load,
    output logic wb_load,
    output logic id_valid,
    output logic ex_valid,
    output logic wb_valid
);

    logic id_allow_in;
    logic ex_allow_in;

    // Writeback retires every cycle, so execute only waits on its own ready_go
    assign ex_allow_in = !ex_valid || ex_ready_go;

    // Decode ready_go is always high
    assign id_allow_in = !id_valid || ex_allow_in;
    assign inst_allow  = id_allow_in;

    // Transfers into each stage register
    assign id_load = inst_valid && id_allow_in;
    assign ex_load = id_valid && ex_allow_in;
    assign wb_load = ex_valid && ex_ready_go;

    // An allowed-in stage takes either the item ahead or a bubble
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end
        else
        begin
            if (id_allow_in)
                id_valid <= inst_valid;
            if (ex_allow_in)
                ex_valid <= id_valid;
            wb_valid <= ex_valid && ex_ready_go;
        end
    end

endmodule

// ==== reg_file.sv ====
module reg_file
    import core_pkg::*;
(
    input  logic              aclk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata
);

    logic [XLEN-1:0] regs [REG_NUM];

    always_ff @(posedge aclk)
    begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== tb_mini_core.sv ====
module tb_mini_core
    import isa_pkg::*, core_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INST = 24;
    localparam int MAX_GAP = 3;
    localparam int TIMEOUT_CYCLES = NUM_INST * (MUL_STEPS + MAX_GAP + 4) + 4 + 16;
    localparam logic [XLEN-1:0] PC_BASE = 32'h1c00_0000;

    logic              aclk = 1'b0;
    logic              reset;
    logic              inst_valid;
    logic [XLEN-1:0]   inst_pc;
    logic [INST_W-1:0] inst_word;
    logic              inst_allow;
    logic [XLEN-1:0]   debug_wb_pc;
    logic              debug_wb_rf_we;
    logic [REG_AW-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]   debug_wb_rf_wdata;

    // Program table, one row per instruction word
    logic [INST_W-1:0] prog_word [NUM_INST];
    bit                prog_tight [NUM_INST];
    logic [XLEN-1:0]   exp_data [NUM_INST];
    logic [XLEN-1:0]   model_regs [REG_NUM];
    int                n_rows = 0;

    int                next_row = 0;
    int                traced = 0;
    int                num_writes = 0;
    int                stall_cycles = 0;
    logic [XLEN-1:0]   last_cnt = '0;
    bit                was_reset = 1'b1;
    integer            seed;
    int                gap;

    mini_core_top dut0 (
        .aclk(aclk), .reset(reset), .inst_valid(inst_valid), .inst_pc(inst_pc),
        .inst_word(inst_word), .inst_allow(inst_allow), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    always #5 aclk = ~aclk;

    function automatic logic [INST_W-1:0] r_type(logic [3:0] op, int rd, int rj, int rk);
        logic [INST_W-1:0] w;
        w = '0;
        w[OPC_MSB:OPC_LSB] = op;
        w[RD_LSB +: REG_AW] = rd[REG_AW-1:0];
        w[RJ_LSB +: REG_AW] = rj[REG_AW-1:0];
        w[RK_LSB +: REG_AW] = rk[REG_AW-1:0];
        return w;
    endfunction

    function automatic logic [INST_W-1:0] i_type(logic [3:0] op, int rd, int rj, int imm);
        logic [INST_W-1:0] w;
        w = r_type(op, rd, rj, 0);
        w[IMM_W-1:0] = imm[IMM_W-1:0];
        return w;
    endfunction

    // A write shows in the trace only for a writing opcode and a non-zero rd
    function automatic bit writes_reg(logic [INST_W-1:0] w);
        logic [3:0] op;
        op = w[OPC_MSB:OPC_LSB];
        return (op inside {OP_ADD, OP_SUB, OP_ADDI, OP_MUL, OP_RDCNTVL, OP_RDCNTVH})
            && (w[RD_LSB +: REG_AW] != '0);
    endfunction

    task automatic add_row(logic [INST_W-1:0] w, bit tight);
        prog_word[n_rows] = w;
        prog_tight[n_rows] = tight;
        n_rows++;
    endtask

    // Reference register model in program order
    task automatic predict_results();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] res;
        logic [3:0]      op;
        for (int r = 0; r < REG_NUM; r++)
            model_regs[r] = (r == 0) ? '0 : 'x;
        for (int i = 0; i < NUM_INST; i++)
        begin
            op = prog_word[i][OPC_MSB:OPC_LSB];
            a = model_regs[prog_word[i][RJ_LSB +: REG_AW]];
            b = model_regs[prog_word[i][RK_LSB +: REG_AW]];
            imm = XLEN'($signed(prog_word[i][IMM_W-1:0]));
            case (op)
                OP_ADD:     res = a + b;
                OP_SUB:     res = a - b;
                OP_ADDI:    res = a + imm;
                OP_MUL:     res = a * b;
                OP_RDCNTVH: res = '0;
                default:    res = 'x;
            endcase
            exp_data[i] = res;
            if (writes_reg(prog_word[i]))
            begin
                model_regs[prog_word[i][RD_LSB +: REG_AW]] = res;
                num_writes++;
            end
        end
    endtask

    task automatic check_value(string what, logic [63:0] got, logic [63:0] expected);
        if (got !== expected)
        begin
            $display("Mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, got, expected);
            $display("Some tests failed");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic check_trace();
        while (next_row < NUM_INST && !writes_reg(prog_word[next_row]))
            next_row++;
        if (next_row >= NUM_INST)
        begin
            $display("Unexpected register write in the trace at time %0t", $time);
            $display("Some tests failed");
            $fatal(1, "Extra trace write");
        end
        else
        begin
            check_value($sformatf("row %0d pc", next_row), debug_wb_pc,
                        PC_BASE + 4 * next_row);
            check_value($sformatf("row %0d wnum", next_row), debug_wb_rf_wnum,
                        prog_word[next_row][RD_LSB +: REG_AW]);
            if (prog_word[next_row][OPC_MSB:OPC_LSB] == OP_RDCNTVL)
            begin
                // Back-to-back reads one cycle apart
                if (prog_tight[next_row])
                    check_value($sformatf("row %0d counter step", next_row),
                                debug_wb_rf_wdata, last_cnt + 1);
                last_cnt = debug_wb_rf_wdata;
            end
            else
            begin
                check_value($sformatf("row %0d wdata", next_row), debug_wb_rf_wdata,
                            exp_data[next_row]);
            end
            next_row++;
            traced++;
        end
    endtask

    // Trace monitor, sampled away from the active edge
    always @(negedge aclk)
    begin
        if (reset || was_reset)
        begin
            check_value("write strobe around reset", debug_wb_rf_we, 1'b0);
            if (!reset)
                check_value("inst_allow after reset", inst_allow, 1'b1);
        end
        else if (debug_wb_rf_we)
        begin
            check_trace();
        end
        if (!reset && inst_valid && !inst_allow)
            stall_cycles++;
        was_reset = reset;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout after %0d cycles with %0d trace writes seen", TIMEOUT_CYCLES, traced);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        reset = 1'b1;
        inst_valid = 1'b0;
        inst_pc = '0;
        inst_word = '0;
        seed = 1;

        // ALU and forwarding
        add_row(i_type(OP_ADDI, 1, 0, 5), 0);
        add_row(i_type(OP_ADDI, 2, 0, -3), 1);
        add_row(r_type(OP_ADD, 3, 1, 2), 1);
        add_row(r_type(OP_SUB, 4, 3, 1), 1);
        add_row(i_type(OP_ADDI, 0, 1, 7), 1);
        add_row(r_type(OP_ADD, 5, 4, 4), 1);
        add_row(i_type(OP_ADDI, 6, 5, -2048), 1);
        // Multiplies with dependents
        add_row(r_type(OP_MUL, 7, 1, 2), 0);
        add_row(r_type(OP_ADD, 8, 7, 1), 1);
        add_row(i_type(OP_ADDI, 9, 0, 2047), 0);
        add_row(r_type(OP_MUL, 10, 9, 9), 0);
        add_row(r_type(OP_MUL, 11, 10, 6), 1);
        // No-write rows
        add_row(r_type(OP_NOP, 12, 1, 2), 0);
        add_row(r_type(4'hf, 12, 1, 2), 0);
        // Counter reads
        add_row(r_type(OP_RDCNTVH, 13, 0, 0), 0);
        add_row(r_type(OP_RDCNTVL, 14, 0, 0), 0);
        add_row(r_type(OP_RDCNTVL, 15, 0, 0), 1);
        add_row(r_type(OP_SUB, 16, 0, 1), 0);
        add_row(r_type(OP_ADD, 17, 16, 3), 1);
        add_row(i_type(OP_ADDI, 1, 1, 1), 1);
        add_row(r_type(OP_ADD, 18, 1, 1), 1);
        add_row(r_type(OP_MUL, 19, 18, 17), 0);
        add_row(r_type(OP_SUB, 20, 19, 8), 0);
        add_row(i_type(OP_ADDI, 21, 20, 100), 1);
        predict_results();

        repeat (4) @(posedge aclk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_INST; i++)
        begin
            gap = prog_tight[i] ? 0 : $unsigned($random(seed)) % (MAX_GAP + 1);
            if (gap > 0)
            begin
                inst_valid <= 1'b0;
                repeat (gap) @(posedge aclk);
            end
            inst_valid <= 1'b1;
            inst_pc <= PC_BASE + 4 * i;
            inst_word <= prog_word[i];
            // Hold the word until the core takes it on a rising edge
            @(negedge aclk);
            while (!inst_allow)
                @(negedge aclk);
            @(posedge aclk);
        end
        inst_valid <= 1'b0;

        while (traced < num_writes)
            @(posedge aclk);
        repeat (10) @(posedge aclk);

        if (stall_cycles > 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            $display("inst_allow never dropped while a multiply was running");
            $display("Some tests failed");
            $fatal(1, "No back-pressure seen");
        end
    end

endmodule

// ==== time_counter.sv ====
module time_counter
    import core_pkg::*;
(
    input  logic             aclk,
    input  logic             reset,
    output logic [CNT_W-1:0] count
);

    // Free-running cycle count for the counter-read instructions
    always_ff @(posedge aclk)
    begin
        if (reset)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule
